// File: Makefile
all: run

obj_dir/VpianoTilesTb: list.f $(wildcard *.sv)
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module pianoTilesTb -f list.f

run: obj_dir/VpianoTilesTb
	./obj_dir/VpianoTilesTb | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: backgroundScanner.sv
module backgroundScanner (
	input logic CLOCK_50,
	input logic rstN,
	input logic gameOn,
	input logic restart,
	output logic sweepDone,
	pixelBus.painter pix
);
	import tilesPkg::*;

	logic active;
	logic sweepOn;  // Screen state latched at restart
	xCoord xCount;
	yCoord yCount;
	logic transfer;
	logic lastColumn;
	logic lastRow;

	assign transfer = pix.valid && pix.ready;
	assign lastColumn = xCount == xCoord'(screenWidth - 1);
	assign lastRow = yCount == yCoord'(screenHeight - 1);

	assign pix.valid = active;
	assign pix.x = xCount;
	assign pix.y = yCount;

	// Black frame when off and white with green lines when on
	assign pix.color = !sweepOn ? colorBlack : (isBorder(xCount) ? colorGreen : colorWhite);

	always_ff @(posedge CLOCK_50)
	begin
		if (!rstN)
		begin
			active <= 1'b0;
			sweepDone <= 1'b0;
			sweepOn <= 1'b0;
			xCount <= '0;
			yCount <= '0;
		end
		else if (restart)
		begin
			active <= 1'b1;
			sweepDone <= 1'b0;
			sweepOn <= gameOn;
			xCount <= '0;
			yCount <= '0;
		end
		else if (transfer)
		begin
			if (!lastColumn)
				xCount <= xCount + 1'b1;  // x runs fastest
			else
			begin
				xCount <= '0;
				if (lastRow)
				begin
					active <= 1'b0;
					sweepDone <= 1'b1;
				end
				else
					yCount <= yCount + 1'b1;
			end
		end
	end

endmodule

// File: gameControl.sv
module gameControl #(
	parameter int stepCycles = 8000
) (
	input logic CLOCK_50,
	input logic rstN,
	input logic key,
	input logic sweepDone,
	output logic gameOn,
	output logic restart,
	output logic stepTick
);

	localparam int countWidth = $clog2(stepCycles + 1);

	logic keyPrev;
	logic press;
	logic [countWidth-1:0] stepCount;

	assign press = keyPrev && !key;  // Key is active low

	// Screen state and toggle pulse
	always_ff @(posedge CLOCK_50)
	begin
		if (!rstN)
		begin
			keyPrev <= 1'b1;
			gameOn <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			keyPrev <= key;
			restart <= press;
			if (press)
				gameOn <= !gameOn;
		end
	end

	// Step timer only runs on a fully swept, active screen
	always_ff @(posedge CLOCK_50)
	begin
		if (!rstN)
		begin
			stepCount <= '0;
			stepTick <= 1'b0;
		end
		else if (press || restart || !(gameOn && sweepDone))
		begin
			stepCount <= '0;  // Stale sweepDone around a toggle
			stepTick <= 1'b0;
		end
		else if (stepCount == countWidth'(stepCycles - 1))
		begin
			stepCount <= '0;
			stepTick <= 1'b1;
		end
		else
		begin
			stepCount <= stepCount + 1'b1;
			stepTick <= 1'b0;
		end
	end

endmodule

// File: list.f
tilesPkg.sv
pixelBus.sv
gameControl.sv
backgroundScanner.sv
tileMover.sv
pixelArbiter.sv
pianoTilesTop.sv
pianoTiles_assertions.sv
pianoTilesTb.sv

// File: pianoTilesTb.sv
module pianoTilesTb;
	timeunit 1ns;
	timeprecision 1ps;
	import tilesPkg::*;

	localparam int frameSize = screenWidth * screenHeight;
	localparam int shownErrors = 8;  // Mismatch lines printed per frame

	logic CLOCK_50;
	logic rstN;
	logic key;
	xCoord vgaX;
	yCoord vgaY;
	pixelColor vgaColor;
	logic plot;

	pixelColor frame [screenHeight][screenWidth];  // Picture as the plotter left it
	int plotTotal = 0;
	int tickCount = 0;
	int tickPlots = 0;  // plotTotal at the latest step tick
	int frameErrors = 0;
	int countErrors = 0;
	int timeouts = 0;
	int seed;
	int tileW;
	int tileH;
	int stepLen;

	pianoTilesTop uut (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.key(key),
		.vgaX(vgaX),
		.vgaY(vgaY),
		.vgaColor(vgaColor),
		.plot(plot)
	);

	always #50 CLOCK_50 = ~CLOCK_50;

	// Plotter outputs sampled mid-cycle
	always @(negedge CLOCK_50)
	begin
		if (plot)
		begin
			plotTotal++;
			assert (int'(vgaX) < screenWidth && int'(vgaY) < screenHeight)
				frame[vgaY][vgaX] = vgaColor;
			else
			begin
				frameErrors++;
				$display("pixel plotted off the screen at (%0d,%0d)", vgaX, vgaY);
			end
		end
		if (uut.stepTick)
		begin
			tickCount++;
			tickPlots = plotTotal;
		end
	end

	// Rows of a tile above the bottom edge
	function automatic int rowsShown(input int top);
		return (top + tileH <= screenHeight) ? tileH : screenHeight - top;
	endfunction

	// Step m erases the tile at row m-1 and paints it at row m
	function automatic int repaintPixels(input int m);
		return columnCount * tileW * (rowsShown((m - 1) % screenHeight) + rowsShown(m % screenHeight));
	endfunction

	function automatic pixelColor expectedColor(input int x, input int y, input bit on,
		input int tileColumns [columnCount], input int tileTops [columnCount]);
		int left;
		pixelColor result;
		result = colorWhite;
		if (!on)
			result = colorBlack;
		else if (x == 40 || x == 80 || x == 120)
			result = colorGreen;
		else
		begin
			for (int t = 0; t < columnCount; t++)
			begin
				left = tileInset + tileColumns[t] * columnWidth;
				if (x >= left && x < left + tileW && y >= tileTops[t] && y < tileTops[t] + tileH)
					result = colorBlack;  // Tiles are black on white
			end
		end
		return result;
	endfunction

	task automatic compareFrame(input string name, input bit on, input int steps);
		int tileColumns [columnCount];
		int tileTops [columnCount];
		int misses;
		pixelColor want;
		misses = 0;
		for (int t = 0; t < columnCount; t++)
		begin
			tileColumns[t] = (t + steps / screenHeight) % columnCount;  // Wraps every 120 steps
			tileTops[t] = steps % screenHeight;
		end
		for (int y = 0; y < screenHeight; y++)
			for (int x = 0; x < screenWidth; x++)
			begin
				want = expectedColor(x, y, on, tileColumns, tileTops);
				assert (frame[y][x] == want)
				else
				begin
					frameErrors++;
					misses++;
					if (misses <= shownErrors)
						$display("[ERROR] %s pixel (%0d,%0d): expected %0d, actual %0d",
							name, x, y, want, frame[y][x]);
				end
			end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			countErrors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic pressKey();
		int hold;
		hold = 2 + ($unsigned($random(seed)) % 8);
		@(negedge CLOCK_50);
		key = 1'b0;
		repeat (hold) @(negedge CLOCK_50);
		key = 1'b1;
		repeat (2) @(negedge CLOCK_50);
	endtask

	task automatic waitSweep(input string name);
		int waited;
		waited = 0;
		while (!uut.sweepDone && waited < 2 * frameSize)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (!uut.sweepDone)
		begin
			timeouts++;
			$display("%s: background sweep never finished", name);
		end
	endtask

	task automatic waitTick(input int n, input string name);
		int waited;
		waited = 0;
		while (tickCount < n && waited < 2 * stepLen)
		begin
			@(posedge CLOCK_50);
			waited++;
		end
		if (tickCount < n)
		begin
			timeouts++;
			$display("%s: step tick %0d never came", name, n);
		end
	endtask

	task automatic waitPlots(input int target, input string name);
		int waited;
		waited = 0;
		while (plotTotal < target && waited < stepLen)
		begin
			@(posedge CLOCK_50);
			waited++;
		end
		if (plotTotal < target)
		begin
			timeouts++;
			$display("%s: only %0d of %0d pixels plotted", name, plotTotal, target);
		end
	endtask

	initial
	begin
		int baseTotal;
		int prevTotal;
		int tickBase;
		CLOCK_50 = 1'b0;
		rstN = 1'b0;
		key = 1'b1;
		seed = 32'h118ab334;
		tileW = uut.tileWidth;
		tileH = uut.tileHeight;
		stepLen = uut.stepCycles;
		repeat (2) @(negedge CLOCK_50);
		rstN = 1'b1;
		repeat (20) @(posedge CLOCK_50);
		checkCount("plots before first press", 0, plotTotal);

		baseTotal = plotTotal;
		pressKey();
		waitSweep("first switch-on");
		prevTotal = baseTotal;
		for (int n = 1; n <= screenHeight + 1; n++)
		begin
			waitTick(n, "falling tiles");
			if (n == 1)
				checkCount("switch-on sweep and paint", frameSize + columnCount * tileW * tileH,
					tickPlots - prevTotal);
			else
				checkCount($sformatf("repaint %0d", n - 1), repaintPixels(n - 1),
					tickPlots - prevTotal);
			prevTotal = tickPlots;
			compareFrame($sformatf("after %0d steps", n - 1), 1'b1, n - 1);
		end

		// Switch off only once the last repaint is out
		waitPlots(prevTotal + repaintPixels(screenHeight + 1), "last repaint");
		baseTotal = plotTotal;
		tickBase = tickCount;
		pressKey();
		waitSweep("switch-off");
		repeat (2 * stepLen) @(posedge CLOCK_50);
		checkCount("plots while off", frameSize, plotTotal - baseTotal);
		checkCount("ticks while off", tickBase, tickCount);
		compareFrame("black screen", 1'b0, 0);

		baseTotal = plotTotal;
		pressKey();
		waitSweep("second switch-on");
		waitTick(tickBase + 1, "restarted tiles");
		checkCount("restart sweep and paint", frameSize + columnCount * tileW * tileH,
			tickPlots - baseTotal);
		compareFrame("after restart", 1'b1, 0);

		$display("frame errors: %0d, count errors: %0d, timeouts: %0d",
			frameErrors, countErrors, timeouts);
		if (frameErrors + countErrors + timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// 130 steps plus four frame sweeps of margin
	initial
	begin
		int limit;
		limit = 130 * uut.stepCycles + 4 * frameSize;
		repeat (limit) @(posedge CLOCK_50);
		$display("watchdog: run still going after %0d cycles", limit);
		$display("frame errors: %0d, count errors: %0d, timeouts: %0d",
			frameErrors, countErrors, timeouts);
		$display("tests failed");
		$finish;
	end

endmodule

// File: pianoTilesTop.sv
module pianoTilesTop #(
	parameter int tileWidth = 36,
	parameter int tileHeight = 20,
	parameter int stepCycles = 8000
) (
	input logic CLOCK_50,
	input logic rstN,
	input logic key,
	output tilesPkg::xCoord vgaX,
	output tilesPkg::yCoord vgaY,
	output tilesPkg::pixelColor vgaColor,
	output logic plot
);
	import tilesPkg::*;

	logic gameOn;
	logic restart;
	logic stepTick;
	logic sweepDone;

	// Background bus last for the lowest priority
	pixelBus buses [columnCount + 1] ();

	gameControl #(
		.stepCycles(stepCycles)
	) control (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.key(key),
		.sweepDone(sweepDone),
		.gameOn(gameOn),
		.restart(restart),
		.stepTick(stepTick)
	);

	backgroundScanner scanner (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.gameOn(gameOn),
		.restart(restart),
		.sweepDone(sweepDone),
		.pix(buses[columnCount])
	);

	for (genvar c = 0; c < columnCount; c++)
	begin : tiles
		tileMover #(
			.tileWidth(tileWidth),
			.tileHeight(tileHeight),
			.startColumn(columnIndex'(c))
		) mover (
			.CLOCK_50(CLOCK_50),
			.rstN(rstN),
			.gameOn(gameOn),
			.restart(restart),
			.stepTick(stepTick),
			.pix(buses[c])
		);
	end

	pixelArbiter plotArbiter (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.src(buses),
		.vgaX(vgaX),
		.vgaY(vgaY),
		.vgaColor(vgaColor),
		.plot(plot)
	);

endmodule

// File: pianoTiles_assertions.sv
module pianoTilesAssertions (
	input logic CLOCK_50,
	input logic rstN,
	input tilesPkg::xCoord vgaX,
	input tilesPkg::yCoord vgaY,
	input tilesPkg::pixelColor vgaColor,
	input logic plot
);
	timeunit 1ns;
	timeprecision 1ps;
	import tilesPkg::*;

	// Plotter never leaves the 160 by 120 screen
	onScreen: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		plot |-> (int'(vgaX) < screenWidth && int'(vgaY) < screenHeight))
		else $error("pixel plotted outside the screen");

	greenOnBorder: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		(plot && vgaColor == colorGreen) |-> (vgaX == 8'd40 || vgaX == 8'd80 || vgaX == 8'd120))
		else $error("green pixel away from a border line");

	// Registered plot clears in the reset cycle
	quietAfterReset: assert property (@(posedge CLOCK_50) !rstN |=> !plot)
		else $error("plot high right after reset");

endmodule

bind pianoTilesTop pianoTilesAssertions checks (
	.CLOCK_50(CLOCK_50),
	.rstN(rstN),
	.vgaX(vgaX),
	.vgaY(vgaY),
	.vgaColor(vgaColor),
	.plot(plot)
);

// File: pixelArbiter.sv
module pixelArbiter (
	input logic CLOCK_50,
	input logic rstN,
	pixelBus.arbiter src [tilesPkg::columnCount + 1],
	output tilesPkg::xCoord vgaX,
	output tilesPkg::yCoord vgaY,
	output tilesPkg::pixelColor vgaColor,
	output logic plot
);
	import tilesPkg::*;

	localparam int sourceCount = columnCount + 1;

	logic [sourceCount-1:0] validVec;
	logic [sourceCount-1:0] grantVec;
	xCoord srcX [sourceCount];
	yCoord srcY [sourceCount];
	pixelColor srcColor [sourceCount];
	xCoord selX;
	yCoord selY;
	pixelColor selColor;

	for (genvar i = 0; i < sourceCount; i++)
	begin : gatherSources
		assign validVec[i] = src[i].valid;
		assign srcX[i] = src[i].x;
		assign srcY[i] = src[i].y;
		assign srcColor[i] = src[i].color;
		assign src[i].ready = grantVec[i];
	end

	// Lowest numbered valid source wins
	assign grantVec = validVec & (~validVec + sourceCount'(1));

	always_comb
	begin
		selX = '0;
		selY = '0;
		selColor = colorBlack;
		for (int i = 0; i < sourceCount; i++)
		begin
			if (grantVec[i])
			begin
				selX = selX | srcX[i];  // Grant is one-hot
				selY = selY | srcY[i];
				selColor = selColor | srcColor[i];
			end
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!rstN)
			plot <= 1'b0;
		else
			plot <= |validVec;
	end

	always_ff @(posedge CLOCK_50)
	begin
		vgaX <= selX;
		vgaY <= selY;
		vgaColor <= selColor;
	end

endmodule

// File: pixelBus.sv
interface pixelBus;
	import tilesPkg::*;

	logic valid;
	logic ready;
	xCoord x;
	yCoord y;
	pixelColor color;

	// Painter holds x, y and color until valid meets ready
	modport painter (
		output valid,
		output x,
		output y,
		output color,
		input ready
	);

	modport arbiter (
		input valid,
		input x,
		input y,
		input color,
		output ready
	);

endinterface

// File: tileMover.sv
module tileMover #(
	parameter int tileWidth = 36,
	parameter int tileHeight = 20,
	parameter tilesPkg::columnIndex startColumn = '0
) (
	input logic CLOCK_50,
	input logic rstN,
	input logic gameOn,
	input logic restart,
	input logic stepTick,
	pixelBus.painter pix
);
	import tilesPkg::*;

	// The background sweep owns the bus for one uncontested frame
	localparam int frameCycles = screenWidth * screenHeight;
	localparam int waitBits = $clog2(frameCycles + 1);
	localparam int xBits = $clog2(tileWidth);
	localparam int yBits = $clog2(tileHeight);

	localparam logic [1:0] phaseIdle = 2'd0;
	localparam logic [1:0] phaseWait = 2'd1;
	localparam logic [1:0] phaseErase = 2'd2;
	localparam logic [1:0] phasePaint = 2'd3;

	logic [1:0] phase;
	columnIndex column;
	yCoord top;  // Tile's top row
	logic [xBits-1:0] xOff;
	logic [yBits-1:0] rOff;
	logic [waitBits-1:0] waitCount;
	logic [7:0] rowNext;  // Wide enough past the bottom edge
	logic transfer;
	logic rowEnd;
	logic walkEnd;

	assign pix.valid = (phase == phaseErase) || (phase == phasePaint);
	assign pix.x = tileLeft(column) + xCoord'(xOff);
	assign pix.y = top + yCoord'(rOff);
	assign pix.color = (phase == phaseErase) ? colorWhite : colorBlack;

	assign transfer = pix.valid && pix.ready;
	assign rowNext = 8'(top) + 8'(rOff) + 8'd1;
	assign rowEnd = xOff == xBits'(tileWidth - 1);

	// Rows from the bottom edge on are clipped, so the walk stops there
	assign walkEnd = (rOff == yBits'(tileHeight - 1)) || (rowNext >= 8'(screenHeight));

	always_ff @(posedge CLOCK_50)
	begin
		if (!rstN)
		begin
			phase <= phaseIdle;
			column <= startColumn;
			top <= '0;
			xOff <= '0;
			rOff <= '0;
			waitCount <= '0;
		end
		else if (restart)
		begin
			column <= startColumn;
			top <= '0;
			xOff <= '0;
			rOff <= '0;
			waitCount <= waitBits'(frameCycles);
			phase <= gameOn ? phaseWait : phaseIdle;
		end
		else
		begin
			case (phase)
				phaseIdle:
					if (stepTick)
						phase <= phaseErase;
				phaseWait:
					if (waitCount == '0)
						phase <= phasePaint;  // First paint at row 0
					else
						waitCount <= waitCount - 1'b1;
				default:
					// Ticks during an erase or paint walk are ignored
					if (transfer)
					begin
						if (!rowEnd)
							xOff <= xOff + 1'b1;
						else
						begin
							xOff <= '0;
							if (!walkEnd)
								rOff <= rOff + 1'b1;
							else
							begin
								rOff <= '0;
								if (phase == phaseErase)
								begin
									phase <= phasePaint;
									if (top == yCoord'(screenHeight - 1))
									begin
										top <= '0;
										column <= column + 2'd1;  // 3 wraps to 0
									end
									else
										top <= top + 1'b1;
								end
								else
									phase <= phaseIdle;
							end
						end
					end
			endcase
		end
	end

endmodule

// File: tilesPkg.sv
package tilesPkg;

	// Screen size in pixels
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;

	// Column geometry
	localparam int borderWidth = 1;
	localparam int columnWidth = 39;
	localparam int columnCount = 4;
	localparam int tileInset = 4;  // Column edge to tile left

	typedef logic [7:0] xCoord;
	typedef logic [6:0] yCoord;
	typedef logic [2:0] pixelColor;
	typedef logic [1:0] columnIndex;

	localparam pixelColor colorBlack = 3'b000;
	localparam pixelColor colorGreen = 3'b010;
	localparam pixelColor colorWhite = 3'b111;

	// Green lines land on x = 40, 80, 120
	function automatic logic isBorder(input xCoord x);
		logic hit;
		hit = 1'b0;
		for (int k = 1; k < columnCount; k++)
		begin
			if (int'(x) == k * (columnWidth + borderWidth))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// Left edge of the tile in column c: 4, 43, 82, 121
	function automatic xCoord tileLeft(input columnIndex c);
		return xCoord'(tileInset + int'(c) * columnWidth);
	endfunction

endpackage
